// File: logic/animPkg.sv
package animPkg;

    typedef logic [3:0] countT;   // animation counter
    typedef logic [2:0] phaseT;   // coarse phase code for the LEDs

    typedef enum logic [4:0] {
        Idle,
        Walk1, Walk2, Walk3, Walk4,
        Sniff1, Sniff2,
        Surprised,
        Jump1, Jump2,
        WaitDuck,
        Launch,
        Hold
    } dogStateT;

    localparam phaseT Rest       = 3'd0;
    localparam phaseT Walking    = 3'd1;
    localparam phaseT Sniffing   = 3'd2;
    localparam phaseT Jumping    = 3'd3;
    localparam phaseT Waiting    = 3'd4;
    localparam phaseT DuckFlight = 3'd5;

    localparam countT SniffStrideA  = 4'd4;   // first sniff after this stride
    localparam countT SniffStrideB  = 4'd7;   // second sniff, ends in surprise
    localparam countT SniffRounds   = 4'd3;
    localparam countT SurpriseTicks = 4'd2;
    localparam countT JumpTicks     = 4'd10;  // entries per arc table
    localparam countT WaitTicks     = 4'd11;

endpackage

// File: logic/spritePkg.sv
package spritePkg;

    typedef logic [9:0] coordT;        // screen coordinate
    typedef logic [4:0] frameT;        // sprite frame index
    typedef logic [1:0] duckColorT;    // 3 folds onto 0

    // bit 0 rightward, bit 1 steep climb
    typedef logic [1:0] duckHeadingT;

    // dog geometry
    localparam coordT GroundY  = 10'd290;
    localparam coordT HoldY    = 10'd318;   // dog raised from the bushes
    localparam coordT DogHomeX = 10'd11;

    // duck flight box
    localparam coordT DuckFloorY = 10'd300;
    localparam coordT DuckMinX   = 10'd16;
    localparam coordT DuckMaxX   = 10'd600;
    localparam coordT DuckTopY   = 10'd32;

    // first duck frame before colour and direction are added
    localparam frameT DuckFrameBase = 5'd8;

endpackage

// File: logic/randomSource.sv
module randomSource
#(
    parameter logic [15:0] RandomSeed = 16'h53de
)
(
    input  logic        ANIM_Clk,
    input  logic        Reset,
    output logic [15:0] randomWord
);

    logic [15:0] shiftA;
    logic [15:0] shiftB;
    logic [15:0] shiftC;

    // 16-bit xorshift with the 7, 9, 8 triple
    always_comb
    begin
        shiftA = randomWord ^ (randomWord << 7);
        shiftB = shiftA ^ (shiftA >> 9);
        shiftC = shiftB ^ (shiftB << 8);
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
            randomWord <= RandomSeed;   // seed must be nonzero
        else
            randomWord <= shiftC;
    end

endmodule

// File: logic/dogControl.sv
module dogControl
    import animPkg::*;
    import spritePkg::*;
#(
    parameter int DogStride = 32
)
(
    input  logic  ANIM_Clk,
    input  logic  Reset,
    input  logic  Run,
    input  logic  duckDone,
    output coordT dogX,
    output coordT dogY,
    output frameT dogFrame,
    output phaseT dogPhase,
    output countT strideCount,
    output logic  launchDuck
);

    localparam coordT StrideStep = coordT'(DogStride);
    localparam coordT ArcEndX    = 10'd437;   // landing spot behind the bushes

    dogStateT state;
    dogStateT nextState;

    countT sniffRound;
    countT surpriseCount;
    countT jumpCount;       // shared by both arcs
    countT waitCount;
    logic  sniffSession;    // set once the first sniff session is done

    countT strideNext;
    logic  lastRound;
    logic  lastSurprise;
    logic  lastJump;
    logic  lastWait;
    coordT strideX;
    logic [19:0] riseArc;   // {x, y}
    logic [19:0] fallArc;

    assign strideNext   = strideCount + 4'd1;
    assign lastRound    = (sniffRound == SniffRounds - 4'd1);
    assign lastSurprise = (surpriseCount == SurpriseTicks - 4'd1);
    assign lastJump     = (jumpCount == JumpTicks - 4'd1);
    assign lastWait     = (waitCount == WaitTicks - 4'd1);
    assign strideX      = DogHomeX + StrideStep * strideCount;
    assign launchDuck   = (state == Launch);

    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
                if (Run)
                    nextState = Walk1;
            Walk1:
                nextState = Walk2;
            Walk2:
                nextState = Walk3;
            Walk3:
                nextState = Walk4;
            Walk4:
                if (strideNext == SniffStrideA || strideNext == SniffStrideB)
                    nextState = Sniff1;
                else
                    nextState = Walk1;
            Sniff1:
                nextState = Sniff2;
            Sniff2:
                if (!lastRound)
                    nextState = Sniff1;
                else if (sniffSession)
                    nextState = Surprised;
                else
                    nextState = Walk1;   // first session goes back to walking
            Surprised:
                if (lastSurprise)
                    nextState = Jump1;
            Jump1:
                if (lastJump)
                    nextState = Jump2;
            Jump2:
                if (lastJump)
                    nextState = WaitDuck;
            WaitDuck:
                if (lastWait)
                    nextState = Launch;
            Launch:
                nextState = Hold;
            Hold:
                if (duckDone)
                    nextState = Idle;
            default:
                nextState = Idle;
        endcase
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state         <= Idle;
            strideCount   <= '0;
            sniffRound    <= '0;
            sniffSession  <= 1'b0;
            surpriseCount <= '0;
            jumpCount     <= '0;
            waitCount     <= '0;
        end
        else
        begin
            state <= nextState;
            case (state)
                Idle:
                begin
                    strideCount  <= '0;
                    sniffRound   <= '0;
                    sniffSession <= 1'b0;
                end
                Walk4:
                    strideCount <= strideNext;
                Sniff2:
                begin
                    sniffRound <= lastRound ? 4'd0 : sniffRound + 4'd1;
                    if (lastRound)
                        sniffSession <= 1'b1;
                end
                Surprised:
                    surpriseCount <= lastSurprise ? 4'd0 : surpriseCount + 4'd1;
                Jump1, Jump2:
                    jumpCount <= lastJump ? 4'd0 : jumpCount + 4'd1;
                WaitDuck:
                    waitCount <= lastWait ? 4'd0 : waitCount + 4'd1;
                default: ;
            endcase
        end
    end

    // rising arc takes x from 267 to 352 while y climbs from 290 to 212
    always_comb
    begin
        case (jumpCount)
            4'd0:    riseArc = {10'd267, 10'd290};
            4'd1:    riseArc = {10'd276, 10'd274};
            4'd2:    riseArc = {10'd285, 10'd260};
            4'd3:    riseArc = {10'd294, 10'd248};
            4'd4:    riseArc = {10'd303, 10'd238};
            4'd5:    riseArc = {10'd312, 10'd229};
            4'd6:    riseArc = {10'd321, 10'd222};
            4'd7:    riseArc = {10'd330, 10'd217};
            4'd8:    riseArc = {10'd341, 10'd213};
            default: riseArc = {10'd352, 10'd212};
        endcase
    end

    // falling arc mirrors the rise from 352 to 437 and back down to the grass
    always_comb
    begin
        case (jumpCount)
            4'd0:    fallArc = {10'd352, 10'd212};
            4'd1:    fallArc = {10'd363, 10'd213};
            4'd2:    fallArc = {10'd374, 10'd217};
            4'd3:    fallArc = {10'd383, 10'd222};
            4'd4:    fallArc = {10'd392, 10'd229};
            4'd5:    fallArc = {10'd401, 10'd238};
            4'd6:    fallArc = {10'd410, 10'd248};
            4'd7:    fallArc = {10'd419, 10'd260};
            4'd8:    fallArc = {10'd428, 10'd274};
            default: fallArc = {ArcEndX, 10'd290};
        endcase
    end

    always_comb
    begin
        dogX     = strideX;   // sniff and surprise stay at the stride end
        dogY     = GroundY;
        dogFrame = 5'd0;
        dogPhase = Rest;
        case (state)
            Idle:
                dogX = DogHomeX;
            Walk1:
            begin
                dogX     = strideX + 10'd8;
                dogFrame = 5'd1;
                dogPhase = Walking;
            end
            Walk2:
            begin
                dogX     = strideX + 10'd16;
                dogFrame = 5'd2;
                dogPhase = Walking;
            end
            Walk3, Walk4:
            begin
                dogX     = (state == Walk3) ? strideX + 10'd24 : strideX + 10'd32;
                dogFrame = 5'd3;
                dogPhase = Walking;
            end
            Sniff1, Sniff2:
            begin
                dogFrame = (state == Sniff1) ? 5'd4 : 5'd5;
                dogPhase = Sniffing;
            end
            Surprised:
            begin
                dogFrame = 5'd6;
                dogPhase = Sniffing;
            end
            Jump1:
            begin
                {dogX, dogY} = riseArc;
                dogFrame     = 5'd7;
                dogPhase     = Jumping;
            end
            Jump2:
            begin
                {dogX, dogY} = fallArc;
                dogFrame     = 5'd8;
                dogPhase     = Jumping;
            end
            WaitDuck, Launch:
            begin
                dogX     = ArcEndX;   // hidden in the bushes
                dogPhase = Waiting;
            end
            Hold:
            begin
                dogX     = ArcEndX;
                dogY     = HoldY;
                dogPhase = DuckFlight;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/duckControl.sv
module duckControl
    import spritePkg::*;
#(
    parameter int DuckStep = 4
)
(
    input  logic        ANIM_Clk,
    input  logic        Reset,
    input  logic        launchDuck,
    input  logic [15:0] randomWord,
    output coordT       duckX,
    output coordT       duckY,
    output frameT       duckFrame,
    output logic        duckActive,
    output logic        duckDone
);

    localparam coordT Step = coordT'(DuckStep);

    duckColorT   color;
    duckColorT   launchColor;
    duckHeadingT heading;
    logic        rightward;     // current horizontal direction
    logic        wing;
    coordT       startX;
    coordT       climb;
    coordT       rightX;
    coordT       leftX;

    assign launchColor = (randomWord[1:0] == 2'd3) ? 2'd0 : randomWord[1:0];
    assign climb       = heading[1] ? Step << 1 : Step;   // steep climb doubles
    assign rightX      = duckX + Step;
    assign leftX       = duckX - Step;
    assign duckFrame   = DuckFrameBase + frameT'({color, rightward, wing});

    // start column clamped into the flight box
    always_comb
    begin
        startX = randomWord[13:4];
        if (startX < DuckMinX)
            startX = DuckMinX;
        else if (startX > DuckMaxX)
            startX = DuckMaxX;
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            duckActive <= 1'b0;
            duckDone   <= 1'b0;
            duckX      <= DuckMinX;
            duckY      <= DuckFloorY;
            color      <= '0;
            heading    <= '0;
            rightward  <= 1'b0;
            wing       <= 1'b0;
        end
        else
        begin
            duckDone <= 1'b0;
            if (launchDuck)
            begin
                color      <= launchColor;
                heading    <= randomWord[3:2];
                rightward  <= randomWord[2];
                duckX      <= startX;
                duckY      <= DuckFloorY;
                wing       <= 1'b0;
                duckActive <= 1'b1;
            end
            else if (duckActive)
            begin
                wing <= ~wing;
                if (duckY <= DuckTopY)
                begin
                    duckActive <= 1'b0;   // gone through the top
                    duckDone   <= 1'b1;
                end
                else
                begin
                    duckY <= duckY - climb;
                    if (rightward ? (rightX > DuckMaxX) : (leftX < DuckMinX))
                    begin
                        rightward <= ~rightward;   // bounce off the side
                        duckX     <= rightward ? leftX : rightX;
                    end
                    else
                        duckX <= rightward ? rightX : leftX;
                end
            end
        end
    end

endmodule

// File: logic/sceneOutput.sv
module sceneOutput
    import animPkg::*;
    import spritePkg::*;
(
    input  logic       ANIM_Clk,
    input  logic       Reset,
    input  logic       Run,
    input  coordT      dogX,
    input  coordT      dogY,
    input  frameT      dogFrame,
    input  coordT      duckX,
    input  coordT      duckY,
    input  frameT      duckFrame,
    input  logic       duckActive,
    input  countT      strideCount,
    input  phaseT      dogPhase,
    output coordT      DogX,
    output coordT      DogY,
    output frameT      DogFrame,
    output coordT      DuckX,
    output coordT      DuckY,
    output frameT      DuckFrame,
    output logic       DuckActive,
    output logic [9:0] Ledr
);

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            DogX       <= DogHomeX;
            DogY       <= GroundY;
            DogFrame   <= '0;
            DuckX      <= DuckMinX;
            DuckY      <= DuckFloorY;
            DuckFrame  <= DuckFrameBase;
            DuckActive <= 1'b0;
            Ledr       <= '0;
        end
        else
        begin
            DogX       <= dogX;
            DogY       <= dogY;
            DogFrame   <= dogFrame;
            DuckX      <= duckX;
            DuckY      <= duckY;
            DuckFrame  <= duckFrame;
            DuckActive <= duckActive;
            // run, jumping flag, duck in flight, phase, strides
            Ledr <= {Run, dogPhase == Jumping, duckActive, dogPhase, strideCount};
        end
    end

endmodule

// File: logic/duckHuntScene.sv
module duckHuntScene
    import animPkg::*;
    import spritePkg::*;
#(
    parameter int          DogStride  = 32,
    parameter int          DuckStep   = 4,
    parameter logic [15:0] RandomSeed = 16'h53de
)
(
    input  logic       ANIM_Clk,
    input  logic       Reset,
    input  logic       Run,
    output coordT      DogX,
    output coordT      DogY,
    output frameT      DogFrame,
    output coordT      DuckX,
    output coordT      DuckY,
    output frameT      DuckFrame,
    output logic       DuckActive,
    output logic [9:0] Ledr
);

    logic [15:0] randomWord;
    coordT       dogX;
    coordT       dogY;
    frameT       dogFrame;
    phaseT       dogPhase;
    countT       strideCount;
    logic        launchDuck;
    coordT       duckX;
    coordT       duckY;
    frameT       duckFrame;
    logic        duckActive;
    logic        duckDone;    // flight over, dog may return to idle

    randomSource #(
        .RandomSeed (RandomSeed)
    ) sources_i (
        .ANIM_Clk   (ANIM_Clk),
        .Reset      (Reset),
        .randomWord (randomWord)
    );

    dogControl #(
        .DogStride (DogStride)
    ) dog_i (
        .ANIM_Clk    (ANIM_Clk),
        .Reset       (Reset),
        .Run         (Run),
        .duckDone    (duckDone),
        .dogX        (dogX),
        .dogY        (dogY),
        .dogFrame    (dogFrame),
        .dogPhase    (dogPhase),
        .strideCount (strideCount),
        .launchDuck  (launchDuck)
    );

    duckControl #(
        .DuckStep (DuckStep)
    ) duck_i (
        .ANIM_Clk   (ANIM_Clk),
        .Reset      (Reset),
        .launchDuck (launchDuck),
        .randomWord (randomWord),
        .duckX      (duckX),
        .duckY      (duckY),
        .duckFrame  (duckFrame),
        .duckActive (duckActive),
        .duckDone   (duckDone)
    );

    sceneOutput out_i (
        .ANIM_Clk    (ANIM_Clk),
        .Reset       (Reset),
        .Run         (Run),
        .dogX        (dogX),
        .dogY        (dogY),
        .dogFrame    (dogFrame),
        .duckX       (duckX),
        .duckY       (duckY),
        .duckFrame   (duckFrame),
        .duckActive  (duckActive),
        .strideCount (strideCount),
        .dogPhase    (dogPhase),
        .DogX        (DogX),
        .DogY        (DogY),
        .DogFrame    (DogFrame),
        .DuckX       (DuckX),
        .DuckY       (DuckY),
        .DuckFrame   (DuckFrame),
        .DuckActive  (DuckActive),
        .Ledr        (Ledr)
    );

endmodule

// File: testbench/duckHuntScene_properties.sv
module duckHuntScene_properties
    import spritePkg::*;
(
    input logic       ANIM_Clk,
    input logic       Reset,
    input logic       Run,
    input logic       launchDuck,
    input logic       DuckActive,
    input coordT      DuckX,
    input logic [9:0] Ledr
);

    timeunit 1ns;
    timeprecision 100ps;

    // launch pulse, then the duck register, then the output stage
    assert property (@(posedge ANIM_Clk) disable iff (Reset)
        $rose(DuckActive) |-> $past(launchDuck, 2))
        else $error("DuckActive rose without a duck launch");

    assert property (@(posedge ANIM_Clk) disable iff (Reset)
        DuckX >= DuckMinX && DuckX <= DuckMaxX)
        else $error("DuckX left the flight box");

    assert property (@(posedge ANIM_Clk) disable iff (Reset)
        Ledr[9] == $past(Run))   // run LED is registered once
        else $error("Ledr bit 9 does not follow Run");

endmodule

bind duckHuntScene duckHuntScene_properties props_i (
    .ANIM_Clk   (ANIM_Clk),
    .Reset      (Reset),
    .Run        (Run),
    .launchDuck (launchDuck),
    .DuckActive (DuckActive),
    .DuckX      (DuckX),
    .Ledr       (Ledr)
);

// File: testbench/duckHuntScene_tb.sv
module duckHuntScene_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WaitLimit  = 2000;   // ticks per wait loop
    localparam int LaunchTick = 74;     // last dog tick before Hold
    localparam int HomeX      = 11;
    localparam int GroundY    = 290;
    localparam int HoldY      = 318;
    localparam int BushX      = 437;    // dog hides here after the jump
    localparam int Stride     = 32;
    localparam int DuckStep   = 4;
    localparam int FloorY     = 300;
    localparam int TopY       = 32;
    localparam int MinX       = 16;
    localparam int MaxX       = 600;
    localparam int FrameBase  = 8;

    // jump arcs with one entry per tick
    localparam int RiseX [10] = '{267, 276, 285, 294, 303, 312, 321, 330, 341, 352};
    localparam int RiseY [10] = '{290, 274, 260, 248, 238, 229, 222, 217, 213, 212};
    localparam int FallX [10] = '{352, 363, 374, 383, 392, 401, 410, 419, 428, 437};
    localparam int FallY [10] = '{212, 213, 217, 222, 229, 238, 248, 260, 274, 290};

    typedef struct packed {
        int x;
        int y;
        int frame;
        int phase;
        int stride;
    } dogViewT;

    logic       ANIM_Clk = 1'b0;
    logic       Reset;
    logic       Run;
    logic [9:0] DogX;
    logic [9:0] DogY;
    logic [4:0] DogFrame;
    logic [9:0] DuckX;
    logic [9:0] DuckY;
    logic [4:0] DuckFrame;
    logic       DuckActive;
    logic [9:0] Ledr;

    logic runQ  = 1'b0;   // Run as the DUT saw it on the last edge
    logic liveQ = 1'b0;   // first edge out of reset has passed
    int   tick;
    bit   tracking    = 1'b0;
    bit   restartNext = 1'b0;
    int   idleStride  = 0;    // stride count still shown on the first Idle tick
    bit   timedOut    = 1'b0;
    int   checks      = 0;
    int   mismatches  = 0;
    int   otherErrors = 0;

    // duck model
    bit duckLive = 1'b0;
    int prevX;
    int prevY;
    int duckDir;
    int duckColor;
    int wingExp;
    int climb;

    duckHuntScene dut_i (
        .ANIM_Clk   (ANIM_Clk),
        .Reset      (Reset),
        .Run        (Run),
        .DogX       (DogX),
        .DogY       (DogY),
        .DogFrame   (DogFrame),
        .DuckX      (DuckX),
        .DuckY      (DuckY),
        .DuckFrame  (DuckFrame),
        .DuckActive (DuckActive),
        .Ledr       (Ledr)
    );

    always #20 ANIM_Clk = ~ANIM_Clk;

    always @(posedge ANIM_Clk)
    begin
        runQ  <= Run;
        liveQ <= !Reset;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // dog view for a tick counted from the Idle tick that saw Run
    function automatic dogViewT dogExpected(input int t);
        dogViewT v;
        int s;
        int w;
        v = '{x: HomeX, y: GroundY, frame: 0, phase: 0, stride: 0};
        if ((t >= 1 && t <= 16) || (t >= 23 && t <= 34))
        begin
            s = (t <= 16) ? (t - 1) / 4 : 4 + (t - 23) / 4;   // strides 0..3, then 4..6
            w = (t <= 16) ? (t - 1) % 4 : (t - 23) % 4;
            v.x      = HomeX + 8 * (w + 1) + Stride * s;
            v.frame  = (w == 0) ? 1 : (w == 1) ? 2 : 3;
            v.phase  = 1;
            v.stride = s;
        end
        else if ((t >= 17 && t <= 22) || (t >= 35 && t <= 42))
        begin
            // sniff rounds at the end of a stride and the surprise after the second session
            v.stride = (t <= 22) ? 4 : 7;
            v.x      = HomeX + Stride * v.stride;
            v.frame  = (t >= 41) ? 6 : (t % 2 == 1) ? 4 : 5;
            v.phase  = 2;
        end
        else if (t >= 43 && t <= 62)
        begin
            v.x      = (t <= 52) ? RiseX[t - 43] : FallX[t - 53];
            v.y      = (t <= 52) ? RiseY[t - 43] : FallY[t - 53];
            v.frame  = (t <= 52) ? 7 : 8;
            v.phase  = 3;
            v.stride = 7;
        end
        else if (t >= 63)
        begin
            v.x      = BushX;
            v.y      = (t > LaunchTick) ? HoldY : GroundY;
            v.phase  = (t > LaunchTick) ? 5 : 4;
            v.stride = 7;
        end
        return v;
    endfunction

    task automatic reportMismatch(input string name, input int got, input int want);
        $display("mismatch %s: got %0h expected %0h (tick %0d)", name, got, want, tick);
        mismatches++;
    endtask

    task automatic checkScene(input dogViewT v, input logic active);
        logic [9:0] expLedr;
        expLedr = {runQ, v.phase == 3, active, v.phase[2:0], v.stride[3:0]};
        checks++;
        if (int'(DogX) != v.x)
            reportMismatch("DogX", int'(DogX), v.x);
        if (int'(DogY) != v.y)
            reportMismatch("DogY", int'(DogY), v.y);
        if (int'(DogFrame) != v.frame)
            reportMismatch("DogFrame", int'(DogFrame), v.frame);
        if (DuckActive !== active)
            reportMismatch("DuckActive", int'(DuckActive), int'(active));
        if (Ledr !== expLedr)
            reportMismatch("Ledr", int'(Ledr), int'(expLedr));
    endtask

    task automatic checkDuck();
        int offset;
        int nextDir;
        int nextX;
        int wantFrame;
        offset = int'(DuckFrame) - FrameBase;
        checks++;
        if (tick == LaunchTick + 1)
        begin
            // first tick in the air
            if (int'(DuckY) != FloorY)
                reportMismatch("DuckY", int'(DuckY), FloorY);
            if (int'(DuckX) < MinX || int'(DuckX) > MaxX)
            begin
                $display("duck launched at column %0d, outside the flight box", int'(DuckX));
                otherErrors++;
            end
            if (offset < 0 || offset / 4 > 2)
            begin
                $display("duck frame %0d does not decode to a colour 0 to 2", int'(DuckFrame));
                otherErrors++;
            end
            if (DuckFrame[0] !== 1'b0)
                reportMismatch("DuckFrame[0]", int'(DuckFrame[0]), 0);
            duckColor = offset / 4;
            duckDir   = (offset / 2) % 2;
            prevX     = int'(DuckX);
            prevY     = FloorY;
            wingExp   = 0;
            climb     = 0;
            duckLive  = 1'b1;
        end
        else if (duckLive && prevY <= TopY)
        begin
            // gone through the top so the position holds
            duckLive    = 1'b0;
            restartNext = 1'b1;
            idleStride  = 7;
            if (int'(DuckX) != prevX)
                reportMismatch("DuckX", int'(DuckX), prevX);
            if (int'(DuckY) != prevY)
                reportMismatch("DuckY", int'(DuckY), prevY);
        end
        else if (duckLive)
        begin
            nextDir = duckDir;
            if (duckDir == 1 && prevX + DuckStep > MaxX)
                nextDir = 0;
            else if (duckDir == 0 && prevX - DuckStep < MinX)
                nextDir = 1;
            nextX   = (nextDir == 1) ? prevX + DuckStep : prevX - DuckStep;
            wingExp = 1 - wingExp;
            if (climb == 0)
            begin
                // steepness is only visible from the first climb step
                climb = prevY - int'(DuckY);
                if (climb != DuckStep && climb != 2 * DuckStep)
                begin
                    $display("first duck climb of %0d is neither one nor two steps", climb);
                    otherErrors++;
                    climb = DuckStep;
                end
            end
            wantFrame = FrameBase + 4 * duckColor + 2 * nextDir + wingExp;
            if (int'(DuckX) != nextX)
                reportMismatch("DuckX", int'(DuckX), nextX);
            if (int'(DuckY) != prevY - climb)
                reportMismatch("DuckY", int'(DuckY), prevY - climb);
            if (int'(DuckFrame) != wantFrame)
                reportMismatch("DuckFrame", int'(DuckFrame), wantFrame);
            duckDir = nextDir;
            prevX   = nextX;
            prevY   = prevY - climb;
        end
    endtask

    // outputs are stable on the falling edge
    always @(negedge ANIM_Clk)
    begin : compare
        dogViewT view;
        if (liveQ)
        begin
            if (restartNext || !tracking)
            begin
                tracking    = runQ;
                tick        = 0;
                restartNext = 1'b0;
            end
            else
                tick++;
            view = dogExpected(tick);
            if (tick == 0)
            begin
                view.stride = idleStride;
                idleStride  = 0;   // cleared while in Idle
            end
            if (tracking && tick > LaunchTick)
                checkDuck();
            checkScene(view, duckLive);
        end
    end

    task automatic waitDuck(input logic level);
        int count;
        count = 0;
        @(negedge ANIM_Clk);
        while (DuckActive !== level && count < WaitLimit)
        begin
            count++;
            @(negedge ANIM_Clk);
        end
        if (DuckActive !== level)
        begin
            $display("timeout: DuckActive did not become %0b in %0d ticks", level, WaitLimit);
            otherErrors++;
            timedOut = 1'b1;
        end
    endtask

    initial
    begin : stimulus
        logic [31:0] seed;
        int          idleTicks;
        Reset     = 1'b1;
        Run       = 1'b0;
        seed      = nextRandom(32'hbc83_53de);
        idleTicks = 4 + int'(seed[2:0]);   // random pause at home before the first run
        repeat (10) @(posedge ANIM_Clk);
        @(negedge ANIM_Clk);
        Reset = 1'b0;
        repeat (idleTicks) @(negedge ANIM_Clk);
        Run = 1'b1;
        for (int cycle = 0; cycle < 3 && !timedOut; cycle++)
        begin
            waitDuck(1'b1);
            if (!timedOut)
                waitDuck(1'b0);
        end
        Run = 1'b0;   // dog stays home after the last flight
        if (!timedOut)
            repeat (6) @(negedge ANIM_Clk);
        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: build.f
logic/animPkg.sv
logic/spritePkg.sv
logic/randomSource.sv
logic/dogControl.sv
logic/duckControl.sv
logic/sceneOutput.sv
logic/duckHuntScene.sv
testbench/duckHuntScene_properties.sv
testbench/duckHuntScene_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the duck hunt scene testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module duckHuntScene_tb -f build.f -o simTop > build.log 2>&1 \
    && ./obj_dir/simTop > sim.log 2>&1 \
    || { cat build.log >> sim.log; echo "TB FAILED" >> sim.log; }
grep -q "TB PASSED" sim.log || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
